//--- sources.f
hw/emu_cfg_pkg.sv
hw/emu_pattern_pkg.sv
hw/pattern_port_if.sv
hw/pattern_ram.sv
hw/host_access.sv
hw/endpoint_gen.sv
hw/delivery_pipe.sv
hw/noc_emulator_top.sv
tests/noc_emulator_asserts.sv
tests/tb_noc_emulator.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the NoC emulator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_noc_emulator -f sources.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out="$(./obj_dir/Vtb_noc_emulator)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Everything OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tests/tb_noc_emulator.sv
/*
 * NoC traffic emulator testbench
 * loads a pattern table into the endpoints, reads it back, runs
 * the traffic and compares the statistics with a model built
 * from the same table
 */
`timescale 1ns/1ps
`default_nettype none

module tb_noc_emulator;
    localparam int NUM_ENDP     = emu_cfg_pkg::NUM_ENDP_DEFAULT;
    localparam int RAM_AW       = emu_cfg_pkg::RAM_AW_DEFAULT;
    localparam int LAT          = emu_cfg_pkg::DELIVERY_LAT_DEFAULT;
    localparam int EW           = emu_cfg_pkg::ENDP_W;
    localparam int DONE_TIMEOUT = 5000;  // cycles

    logic                       clk, reset;
    logic [EW-1:0]              host_sel, stat_sel;
    logic [31:0]                host_data, host_q, stat_data;
    logic                       host_set_addr, host_write, host_read, start, done;
    emu_pattern_pkg::stat_sel_t stat_code;

    logic [EW-1:0]                 tbl_endp [16];
    logic [RAM_AW-1:0]             tbl_addr [16];
    emu_pattern_pkg::pattern_row_t tbl_row  [16];
    int n_rows, errors, checks, min_cycles, cycles, next_addr;
    int exp_stat [NUM_ENDP][4];  // indexed by stat code
    logic [31:0] rd_word;

    noc_emulator_top #(.NUM_ENDP(NUM_ENDP), .RAM_AW(RAM_AW), .DELIVERY_LAT(LAT)) dut_i (
        .clk(clk), .reset(reset), .host_sel_i(host_sel), .host_data_i(host_data),
        .host_set_addr_i(host_set_addr), .host_write_i(host_write),
        .host_read_i(host_read), .host_q_o(host_q), .start_i(start), .done_o(done),
        .stat_sel_i(stat_sel), .stat_code_i(stat_code), .stat_data_o(stat_data)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic emu_pattern_pkg::pattern_row_t make_row(input int cnt, input int gap,
                                                               input int dest, input bit last);
        emu_pattern_pkg::pattern_row_t r;
        r.pkt_count = 16'(cnt);
        r.gap       = 8'(gap);
        r.dest      = 7'(dest);
        r.last      = last;
        return r;
    endfunction

    task automatic add_row(input int ep, input int addr, input logic [31:0] word);
        tbl_endp[n_rows] = EW'(ep);
        tbl_addr[n_rows] = RAM_AW'(addr);
        tbl_row[n_rows]  = word;
        n_rows++;
    endtask

    task automatic fill_table();
        n_rows = 0;
        add_row(0, 0, 32'd1);                    // two passes
        add_row(0, 1, make_row(3, 2, 1, 1'b0));
        add_row(0, 2, make_row(2, 0, 0, 1'b0));  // own index, skipped
        add_row(0, 3, make_row(2, 1, 2, 1'b1));
        add_row(1, 0, 32'd0);
        add_row(1, 1, make_row(4, 0, 2, 1'b0));
        add_row(1, 2, make_row(1, 3, 0, 1'b1));
        add_row(2, 0, 32'd2);
        add_row(2, 1, make_row(2, 1, 0, 1'b1));
        add_row(3, 0, 32'd0);
        add_row(3, 1, make_row(2, 200, 1, 1'b1)); // long gap holds done low
    endtask

    // expected statistics and a lower bound on the run length
    task automatic compute_expected();
        int repeats [NUM_ENDP];
        int busy [NUM_ENDP];
        int ep, dst, n;
        for (int e = 0; e < NUM_ENDP; e++) begin
            repeats[e] = 0;
            busy[e]    = 0;
            for (int c = 0; c < 4; c++) exp_stat[e][c] = 0;
        end
        for (int k = 0; k < n_rows; k++) begin
            if (tbl_addr[k] == '0) repeats[tbl_endp[k]] = int'(tbl_row[k][15:0]);
        end
        for (int k = 0; k < n_rows; k++) begin
            ep  = int'(tbl_endp[k]);
            dst = int'(tbl_row[k].dest[EW-1:0]);
            n   = int'(tbl_row[k].pkt_count) * (repeats[ep] + 1);
            if (tbl_addr[k] != '0 && dst != ep) begin
                exp_stat[ep][0]  += n;
                exp_stat[dst][1] += n;
                busy[ep] += n * (1 + int'(tbl_row[k].gap));  // pulse plus gap
            end
        end
        min_cycles = 0;
        for (int e = 0; e < NUM_ENDP; e++) begin
            exp_stat[e][2] = exp_stat[e][1] * LAT;
            exp_stat[e][3] = (exp_stat[e][1] != 0) ? LAT : 0;
            if (emu_cfg_pkg::START_DELAY + busy[e] > min_cycles) begin
                min_cycles = emu_cfg_pkg::START_DELAY + busy[e];
            end
        end
    endtask

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("Fail at %0t ns: %s = 0x%08h, expected 0x%08h", $time, name, got, exp);
    endtask

    // one-cycle strobe, then idle so strobes stay three cycles apart
    task automatic set_address(input int addr);
        @(negedge clk);
        host_data     = 32'(addr);
        host_set_addr = 1'b1;
        @(negedge clk);
        host_set_addr = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic write_word(input logic [31:0] word);
        @(negedge clk);
        host_data  = word;
        host_write = 1'b1;
        @(negedge clk);
        host_write = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic read_word(output logic [31:0] word);
        @(negedge clk);
        host_read = 1'b1;
        @(negedge clk);
        host_read = 1'b0;
        repeat (2) @(negedge clk);  // address cycle plus ram cycle
        word = host_q;
    endtask

    task automatic check_stats(input bit after_run);
        int exp;
        for (int e = 0; e < NUM_ENDP; e++) begin
            for (int c = 0; c < 4; c++) begin
                @(negedge clk);
                stat_sel  = EW'(e);
                stat_code = emu_pattern_pkg::stat_sel_t'(2'(c));
                #1;
                exp = after_run ? exp_stat[e][c] : 0;
                checks++;
                if (stat_data !== 32'(exp)) begin
                    report_value($sformatf("stat_data_o[%0d].%s", e, stat_code.name()),
                                 stat_data, 32'(exp));
                end
            end
        end
    endtask

    initial begin
        errors        = 0;
        checks        = 0;
        reset         = 1'b1;
        host_sel      = '0;
        host_data     = '0;
        host_set_addr = 1'b0;
        host_write    = 1'b0;
        host_read     = 1'b0;
        start         = 1'b0;
        stat_sel      = '0;
        stat_code     = emu_pattern_pkg::STAT_SENT;
        fill_table();
        compute_expected();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        checks += 2;
        if (done !== 1'b0) report_value("done_o", 32'(done), 32'd0);
        if (host_q !== 32'd0) report_value("host_q_o", host_q, 32'd0);
        check_stats(1'b0);

        // rows of one endpoint follow each other, so auto-increment does the rest
        @(negedge clk);
        next_addr = -1;
        for (int k = 0; k < n_rows; k++) begin
            host_sel = tbl_endp[k];
            if (int'(tbl_addr[k]) != next_addr) set_address(int'(tbl_addr[k]));
            write_word(tbl_row[k]);
            next_addr = int'(tbl_addr[k]) + 1;
        end
        for (int k = 0; k < n_rows; k++) begin
            host_sel = tbl_endp[k];
            set_address(int'(tbl_addr[k]));
            read_word(rd_word);
            checks++;
            if (rd_word !== tbl_row[k]) begin
                report_value($sformatf("host_q_o[%0d][%0d]", tbl_endp[k], tbl_addr[k]),
                             rd_word, tbl_row[k]);
            end
        end

        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (done !== 1'b1 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        if (done !== 1'b1) begin
            errors++;
            $display("done_o did not rise within %0d cycles of start", DONE_TIMEOUT);
        end else if (cycles < min_cycles) begin
            errors++;
            $display("done_o rose after %0d cycles, the patterns need at least %0d",
                     cycles, min_cycles);
        end

        repeat (LAT + 2) @(negedge clk);  // last packets drain
        check_stats(1'b1);
        checks++;
        if (done !== 1'b1) report_value("done_o", 32'(done), 32'd1);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/noc_emulator_asserts.sv
/*
 * NoC traffic emulator port assertions
 * done level behavior and host read-data stability,
 * bound to the top level
 */
`timescale 1ns/1ps
`default_nettype none

module noc_emulator_asserts (
    input wire        clk,
    input wire        reset,
    input wire        host_read_i,
    input wire [31:0] host_q_o,
    input wire        done_o
);
    // once every pattern is finished the level holds
    done_holds: assert property (@(posedge clk) disable iff (reset) done_o |=> done_o)
        else $error("done_o fell without a reset");

    // capture lands two edges after the strobe edge
    q_stable: assert property (@(posedge clk) disable iff (reset)
                               !$past(host_read_i, 3) |-> $stable(host_q_o))
        else $error("host_q_o changed without a read strobe");

    done_low_in_reset: assert property (@(posedge clk) reset |-> !done_o)
        else $error("done_o high during reset");

endmodule

bind noc_emulator_top noc_emulator_asserts u_port_asserts (
    .clk         (clk),
    .reset       (reset),
    .host_read_i (host_read_i),
    .host_q_o    (host_q_o),
    .done_o      (done_o)
);

`default_nettype wire

//--- hw/noc_emulator_top.sv
/*
 * NoC traffic emulator top level
 * host pattern port, NUM_ENDP endpoint generators and the
 * fixed-latency delivery pipeline, with done and statistics readout
 */
`timescale 1ns/1ps
`default_nettype none

module noc_emulator_top #(
    parameter int NUM_ENDP     = emu_cfg_pkg::NUM_ENDP_DEFAULT,
    parameter int RAM_AW       = emu_cfg_pkg::RAM_AW_DEFAULT,
    parameter int DELIVERY_LAT = emu_cfg_pkg::DELIVERY_LAT_DEFAULT
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [emu_cfg_pkg::ENDP_W-1:0]   host_sel_i,
    input  wire  [emu_cfg_pkg::WORD_W-1:0]   host_data_i,
    input  wire                              host_set_addr_i,
    input  wire                              host_write_i,
    input  wire                              host_read_i,
    output logic [emu_cfg_pkg::WORD_W-1:0]   host_q_o,
    input  wire                              start_i,
    output logic                             done_o,
    input  wire  [emu_cfg_pkg::ENDP_W-1:0]   stat_sel_i,
    input  var   emu_pattern_pkg::stat_sel_t stat_code_i,
    output logic [emu_cfg_pkg::WORD_W-1:0]   stat_data_o
);
    localparam int EW = emu_cfg_pkg::ENDP_W;
    localparam int SW = emu_cfg_pkg::STAMP_W;

    logic [NUM_ENDP-1:0]                       send, done_vec;
    logic [NUM_ENDP-1:0][EW-1:0]               send_dest;
    logic [NUM_ENDP-1:0][SW-1:0]               send_stamp, arrive_stamp;
    logic [NUM_ENDP-1:0][EW:0]                 arrive;
    logic [emu_cfg_pkg::WORD_W-1:0]            stat_all [NUM_ENDP];

    pattern_port_if #(.NUM_ENDP(NUM_ENDP), .RAM_AW(RAM_AW)) pport ();

    host_access #(.NUM_ENDP(NUM_ENDP), .RAM_AW(RAM_AW)) u_host (
        .clk             (clk),
        .reset           (reset),
        .host_sel_i      (host_sel_i),
        .host_data_i     (host_data_i),
        .host_set_addr_i (host_set_addr_i),
        .host_write_i    (host_write_i),
        .host_read_i     (host_read_i),
        .host_q_o        (host_q_o),
        .pport           (pport)
    );

    for (genvar i = 0; i < NUM_ENDP; i++) begin : g_endp
        endpoint_gen #(.ENDP_IDX(i), .RAM_AW(RAM_AW)) u_endp (
            .clk            (clk),
            .reset          (reset),
            .start_i        (start_i),
            .pport          (pport),
            .arrive_i       (arrive[i]),
            .arrive_stamp_i (arrive_stamp[i]),
            .send_o         (send[i]),
            .send_dest_o    (send_dest[i]),
            .send_stamp_o   (send_stamp[i]),
            .done_o         (done_vec[i]),
            .stat_code_i    (stat_code_i),
            .stat_o         (stat_all[i])
        );
    end

    delivery_pipe #(.NUM_ENDP(NUM_ENDP), .DELIVERY_LAT(DELIVERY_LAT)) u_pipe (
        .clk            (clk),
        .reset          (reset),
        .send_i         (send),
        .send_dest_i    (send_dest),
        .send_stamp_i   (send_stamp),
        .arrive_o       (arrive),
        .arrive_stamp_o (arrive_stamp)
    );

    assign done_o      = &done_vec;            // all patterns finished
    assign stat_data_o = stat_all[stat_sel_i];

endmodule

`default_nettype wire

//--- hw/delivery_pipe.sv
/*
 * Fixed-latency delivery pipeline
 * carries every source's packets through DELIVERY_LAT register
 * stages and hands them to their destination endpoint
 */
`timescale 1ns/1ps
`default_nettype none

module delivery_pipe #(
    parameter int NUM_ENDP     = emu_cfg_pkg::NUM_ENDP_DEFAULT,
    parameter int DELIVERY_LAT = emu_cfg_pkg::DELIVERY_LAT_DEFAULT
) (
    input  wire                                                clk,
    input  wire                                                reset,
    input  wire  [NUM_ENDP-1:0]                                send_i,
    input  wire  [NUM_ENDP-1:0][emu_cfg_pkg::ENDP_W-1:0]       send_dest_i,
    input  wire  [NUM_ENDP-1:0][emu_cfg_pkg::STAMP_W-1:0]      send_stamp_i,
    output logic [NUM_ENDP-1:0][emu_cfg_pkg::ENDP_W:0]         arrive_o,
    output logic [NUM_ENDP-1:0][emu_cfg_pkg::STAMP_W-1:0]      arrive_stamp_o
);
    localparam int EW   = emu_cfg_pkg::ENDP_W;
    localparam int LAST = DELIVERY_LAT - 1;

    logic [NUM_ENDP-1:0]                          vld_q [DELIVERY_LAT];
    logic [NUM_ENDP-1:0][EW-1:0]                  dst_q [DELIVERY_LAT];
    logic [NUM_ENDP-1:0][emu_cfg_pkg::STAMP_W-1:0] stp_q [DELIVERY_LAT];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int s = 0; s < DELIVERY_LAT; s++) vld_q[s] <= '0;
        end else begin
            vld_q[0] <= send_i;
            for (int s = 1; s < DELIVERY_LAT; s++) vld_q[s] <= vld_q[s-1];
        end
    end

    always_ff @(posedge clk) begin
        dst_q[0] <= send_dest_i;
        stp_q[0] <= send_stamp_i;
        for (int s = 1; s < DELIVERY_LAT; s++) begin
            dst_q[s] <= dst_q[s-1];
            stp_q[s] <= stp_q[s-1];
        end
    end

    // same latency for all, so colliding packets carry one stamp
    always_comb begin
        for (int d = 0; d < NUM_ENDP; d++) begin
            arrive_o[d]       = '0;
            arrive_stamp_o[d] = '0;
            for (int s = 0; s < NUM_ENDP; s++) begin
                if (vld_q[LAST][s] && dst_q[LAST][s] == EW'(d)) begin
                    arrive_o[d]       = arrive_o[d] + 1'b1;
                    arrive_stamp_o[d] = stp_q[LAST][s];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/endpoint_gen.sv
/*
 * Endpoint traffic generator
 * waits the start delay, walks its pattern rows sending one
 * packet per pulse with a gap timer between packets, and keeps
 * sent, received, total latency and worst latency counters
 */
`timescale 1ns/1ps
`default_nettype none

module endpoint_gen #(
    parameter int ENDP_IDX = 0,
    parameter int RAM_AW   = emu_cfg_pkg::RAM_AW_DEFAULT
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              start_i,
    pattern_port_if.mem                      pport,
    input  wire  [emu_cfg_pkg::ENDP_W:0]     arrive_i,      // arrivals this cycle
    input  wire  [emu_cfg_pkg::STAMP_W-1:0]  arrive_stamp_i,
    output logic                             send_o,
    output logic [emu_cfg_pkg::ENDP_W-1:0]   send_dest_o,
    output logic [emu_cfg_pkg::STAMP_W-1:0]  send_stamp_o,
    output logic                             done_o,
    input  var   emu_pattern_pkg::stat_sel_t stat_code_i,
    output logic [emu_cfg_pkg::WORD_W-1:0]   stat_o
);
    localparam int EW    = emu_cfg_pkg::ENDP_W;
    localparam int WW    = emu_cfg_pkg::WORD_W;
    localparam int SW    = emu_cfg_pkg::STAMP_W;
    localparam int RW    = emu_pattern_pkg::REPEAT_W;
    localparam int DLY_W = $clog2(emu_cfg_pkg::START_DELAY + 1);
    localparam logic [DLY_W-1:0] DLY_LAST = DLY_W'(emu_cfg_pkg::START_DELAY - 1);

    emu_pattern_pkg::seq_state_t   state;
    emu_pattern_pkg::pattern_row_t row;
    logic [RAM_AW-1:0] seq_addr;
    logic [WW-1:0]     host_q;
    logic [DLY_W-1:0]  delay_cnt;
    logic [RW-1:0]     rep_cnt;
    logic [15:0]       pkt_cnt;
    logic [7:0]        gap_cnt;
    logic [SW-1:0]     now_q, latency;
    logic [WW-1:0]     sent_cnt, rcvd_cnt, lat_total, lat_worst;
    logic              skip_row, gap_end, row_done, pkt_fire;

    pattern_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk        (clk),
        .endp_idx_i (EW'(ENDP_IDX)),
        .pport      (pport),
        .seq_addr_i (seq_addr),
        .seq_q_o    (row),
        .host_q_o   (host_q)
    );

    assign pport.rdata[ENDP_IDX] = host_q;

    // self-destined and empty rows send nothing
    assign skip_row = (row.dest[EW-1:0] == EW'(ENDP_IDX)) || (row.pkt_count == '0);
    assign pkt_fire = (state == emu_pattern_pkg::SEQ_SEND) && !skip_row;
    assign gap_end  = (gap_cnt == row.gap - 8'd1);
    assign latency  = now_q - arrive_stamp_i;
    assign done_o   = (state == emu_pattern_pkg::SEQ_DONE);

    always_comb begin
        case (state)
            emu_pattern_pkg::SEQ_SEND:
                row_done = skip_row || (row.gap == '0 && pkt_cnt + 16'd1 == row.pkt_count);
            emu_pattern_pkg::SEQ_GAP:
                row_done = gap_end && (pkt_cnt == row.pkt_count);
            default: row_done = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= emu_pattern_pkg::SEQ_IDLE;
            seq_addr  <= '0;
            delay_cnt <= '0;
            rep_cnt   <= '0;
            pkt_cnt   <= '0;
            gap_cnt   <= '0;
        end else begin
            case (state)
                emu_pattern_pkg::SEQ_IDLE: begin
                    if (start_i) begin
                        rep_cnt   <= row[RW-1:0];  // row 0 sits on the sequencer port
                        delay_cnt <= '0;
                        state     <= emu_pattern_pkg::SEQ_DELAY;
                    end
                end
                emu_pattern_pkg::SEQ_DELAY: begin
                    delay_cnt <= delay_cnt + 1'b1;
                    if (delay_cnt == DLY_LAST) begin
                        seq_addr <= RAM_AW'(1);
                        state    <= emu_pattern_pkg::SEQ_FETCH;
                    end
                end
                emu_pattern_pkg::SEQ_FETCH: begin  // wait for the ram read
                    pkt_cnt <= '0;
                    state   <= emu_pattern_pkg::SEQ_SEND;
                end
                emu_pattern_pkg::SEQ_SEND, emu_pattern_pkg::SEQ_GAP: begin
                    if (row_done) begin
                        if (!row.last) begin
                            seq_addr <= seq_addr + 1'b1;
                            state    <= emu_pattern_pkg::SEQ_FETCH;
                        end else if (rep_cnt != '0) begin
                            rep_cnt  <= rep_cnt - 1'b1;  // another pass
                            seq_addr <= RAM_AW'(1);
                            state    <= emu_pattern_pkg::SEQ_FETCH;
                        end else begin
                            state <= emu_pattern_pkg::SEQ_DONE;
                        end
                    end else if (state == emu_pattern_pkg::SEQ_GAP) begin
                        gap_cnt <= gap_cnt + 1'b1;
                        if (gap_end) state <= emu_pattern_pkg::SEQ_SEND;
                    end else begin
                        pkt_cnt <= pkt_cnt + 1'b1;
                        gap_cnt <= '0;
                        if (row.gap != '0) state <= emu_pattern_pkg::SEQ_GAP;
                    end
                end
                default: ;  // done holds until reset
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            now_q     <= '0;
            send_o    <= 1'b0;
            sent_cnt  <= '0;
            rcvd_cnt  <= '0;
            lat_total <= '0;
            lat_worst <= '0;
        end else begin
            now_q  <= now_q + 1'b1;
            send_o <= pkt_fire;
            if (pkt_fire) sent_cnt <= sent_cnt + 1'b1;
            if (arrive_i != '0) begin
                rcvd_cnt  <= rcvd_cnt + WW'(arrive_i);
                lat_total <= lat_total + WW'(arrive_i) * WW'(latency);
                if (WW'(latency) > lat_worst) lat_worst <= WW'(latency);
            end
        end
    end

    // stamp is the time seen once the pulse is out
    always_ff @(posedge clk) begin
        send_dest_o  <= row.dest[EW-1:0];
        send_stamp_o <= now_q + 1'b1;
    end

    always_comb begin
        case (stat_code_i)
            emu_pattern_pkg::STAT_SENT:      stat_o = sent_cnt;
            emu_pattern_pkg::STAT_RECEIVED:  stat_o = rcvd_cnt;
            emu_pattern_pkg::STAT_TOTAL_LAT: stat_o = lat_total;
            default:                         stat_o = lat_worst;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/host_access.sv
/*
 * Host access controller
 * decodes the set-address, write and read strobes of the host,
 * keeps an auto-incrementing address and captures read data
 * from the selected endpoint's pattern memory
 */
`timescale 1ns/1ps
`default_nettype none

module host_access #(
    parameter int NUM_ENDP = emu_cfg_pkg::NUM_ENDP_DEFAULT,
    parameter int RAM_AW   = emu_cfg_pkg::RAM_AW_DEFAULT
) (
    input  wire                              clk,
    input  wire                              reset,
    input  wire  [emu_cfg_pkg::ENDP_W-1:0]   host_sel_i,
    input  wire  [emu_cfg_pkg::WORD_W-1:0]   host_data_i,
    input  wire                              host_set_addr_i,
    input  wire                              host_write_i,
    input  wire                              host_read_i,
    output logic [emu_cfg_pkg::WORD_W-1:0]   host_q_o,
    pattern_port_if.host                     pport
);
    localparam int EW = emu_cfg_pkg::ENDP_W;

    typedef enum logic [1:0] {H_IDLE, H_WRITE, H_READ} host_state_t;

    host_state_t                    ps, ns;
    logic [RAM_AW-1:0]              addr_q;
    logic [emu_cfg_pkg::WORD_W-1:0] wdata_q;
    logic                           cap_q;   // ram output settled, take it

    assign pport.addr  = addr_q;
    assign pport.wdata = wdata_q;

    always_comb begin
        ns = ps;
        case (ps)
            H_IDLE: begin
                if (host_write_i) ns = H_WRITE;
                else if (host_read_i) ns = H_READ;
            end
            default: ns = H_IDLE;  // write and read take one cycle each
        endcase
    end

    // only the selected memory sees the write
    always_comb begin
        for (int i = 0; i < NUM_ENDP; i++) begin
            pport.we[i] = (ps == H_WRITE) && (host_sel_i == EW'(i));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ps       <= H_IDLE;
            addr_q   <= '0;
            cap_q    <= 1'b0;
            host_q_o <= '0;
        end else begin
            ps    <= ns;
            cap_q <= (ps == H_READ);
            if (host_set_addr_i) addr_q <= host_data_i[RAM_AW-1:0];
            else if (ps == H_WRITE) addr_q <= addr_q + 1'b1;  // next row
            if (cap_q) host_q_o <= pport.rdata[host_sel_i];
        end
    end

    always_ff @(posedge clk) begin
        if (host_write_i) wdata_q <= host_data_i;
    end

endmodule

`default_nettype wire

//--- hw/pattern_ram.sv
/*
 * Pattern memory
 * synchronous dual-port RAM, host side writes and reads,
 * sequencer side reads one pattern row per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module pattern_ram #(
    parameter int RAM_AW = emu_cfg_pkg::RAM_AW_DEFAULT
) (
    input  wire                               clk,
    input  wire  [emu_cfg_pkg::ENDP_W-1:0]    endp_idx_i,
    pattern_port_if.mem                       pport,
    input  wire  [RAM_AW-1:0]                 seq_addr_i,
    output emu_pattern_pkg::pattern_row_t     seq_q_o,
    output logic [emu_cfg_pkg::WORD_W-1:0]    host_q_o   // host-side read word
);
    logic [emu_cfg_pkg::WORD_W-1:0] mem [2**RAM_AW];

    // host port
    always_ff @(posedge clk) begin
        if (pport.we[endp_idx_i]) mem[pport.addr] <= pport.wdata;
        host_q_o <= mem[pport.addr];
    end

    always_ff @(posedge clk) begin
        seq_q_o <= mem[seq_addr_i];  // read only
    end

endmodule

`default_nettype wire

//--- hw/pattern_port_if.sv
/*
 * Pattern memory host port
 * shared address and write data, one write enable and one
 * read-data word per endpoint pattern memory
 */
`timescale 1ns/1ps
`default_nettype none

interface pattern_port_if #(
    parameter int NUM_ENDP = emu_cfg_pkg::NUM_ENDP_DEFAULT,
    parameter int RAM_AW   = emu_cfg_pkg::RAM_AW_DEFAULT
);
    logic [RAM_AW-1:0]              addr;
    logic [emu_cfg_pkg::WORD_W-1:0] wdata;
    logic [NUM_ENDP-1:0]            we;     // one per pattern memory
    logic [emu_cfg_pkg::WORD_W-1:0] rdata [NUM_ENDP];

    modport host (output addr, output wdata, output we, input rdata);
    modport mem  (input addr, input wdata, input we, output rdata);
endinterface

`default_nettype wire

//--- hw/emu_pattern_pkg.sv
/*
 * NoC traffic emulator pattern definitions
 * layout of one pattern row, statistic selector codes
 * and the state encoding of the endpoint sequencer
 */
`default_nettype none

package emu_pattern_pkg;

    localparam int REPEAT_W = 16;  // repeat count in the low bits of row 0

    typedef struct packed {
        logic [15:0] pkt_count;  // packets sent by this row
        logic [7:0]  gap;        // idle cycles after each packet
        logic [6:0]  dest;       // low ENDP_W bits used
        logic        last;       // wraps back to row 1
    } pattern_row_t;

    typedef enum logic [1:0] {
        STAT_SENT,
        STAT_RECEIVED,
        STAT_TOTAL_LAT,
        STAT_WORST_LAT
    } stat_sel_t;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_DELAY,
        SEQ_FETCH,
        SEQ_SEND,
        SEQ_GAP,
        SEQ_DONE
    } seq_state_t;

endpackage

`default_nettype wire

//--- hw/emu_cfg_pkg.sv
/*
 * NoC traffic emulator configuration
 * sizing constants and default parameter values shared by the
 * host port, the endpoint generators and the delivery pipeline
 */
`default_nettype none

package emu_cfg_pkg;

    localparam int NUM_ENDP_DEFAULT = 4;
    localparam int ENDP_W           = $clog2(NUM_ENDP_DEFAULT);  // endpoint index

    localparam int RAM_AW_DEFAULT = 4;   // 16 pattern rows per endpoint
    localparam int WORD_W         = 32;  // pattern rows and statistics

    // cycles from start to the first fetch of row 1
    localparam int START_DELAY = 12;

    localparam int DELIVERY_LAT_DEFAULT = 3;
    localparam int STAMP_W              = 16;  // free-running time stamp

endpackage

`default_nettype wire
